// File: build.f
design/srcIsaPkg.sv
design/srcDatapathPkg.sv
design/controlSequencer.sv
design/registerFile.sv
design/aluUnit.sv
design/memoryInterface.sv
design/miniSrcTop.sv
verification/miniSrcTb.sv

// File: Bender.yml
package:
  name: mini_src

sources:
  - design/srcIsaPkg.sv
  - design/srcDatapathPkg.sv
  - design/controlSequencer.sv
  - design/registerFile.sv
  - design/aluUnit.sv
  - design/memoryInterface.sv
  - design/miniSrcTop.sv
  - target: test
    files:
      - verification/miniSrcTb.sv

// File: verification/miniSrcTb.sv
`timescale 1ns/1ps

module miniSrcTb;
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    localparam int memWords      = 256;
    localparam int programLength = 40;    // halt sits at this address
    localparam int dataBase      = 128;   // ld/st region up to the top word
    localparam int resetCycles   = 4;
    localparam int eventTimeout  = 1000;  // cycles allowed per wait
    localparam int haltWatch     = 50;

    logic                        clock;
    logic                        reset;
    logic                        preloadWrite;
    logic [$clog2(memWords)-1:0] preloadAddress;
    logic [31:0]                 preloadData;
    logic [31:0]                 outData;
    logic                        outValid;
    logic                        halted;

    integer      seed;
    int          errorCount;
    bit          timedOut;
    logic [31:0] image [memWords];      // words written through the preload port
    logic [31:0] modelMem [memWords];   // reference memory
    logic [31:0] modelRegs [regCount];  // reference registers
    logic [31:0] expectedOut [$];       // out values in program order

    miniSrcTop dut (
        .clock         (clock),
        .reset         (reset),
        .preloadWrite  (preloadWrite),
        .preloadAddress(preloadAddress),
        .preloadData   (preloadData),
        .outData       (outData),
        .outValid      (outValid),
        .halted        (halted)
    );

    always #4 clock = ~clock;  // 8 ns period

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // random program plus the reference run of it
    task automatic buildProgram();
        opcodeT      choices [7];
        opcodeT      op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] c;
        logic [31:0] cExt;
        choices = '{ld, st, addi, andi, ori, outOp, nop};
        for (int a = 0; a < memWords; a++) begin
            image[a]    = (a >= dataBase) ? $random(seed) : 32'h0;
            modelMem[a] = image[a];
        end
        for (int r = 0; r < regCount; r++) begin
            modelRegs[r] = '0;  // registers clear on reset
        end
        expectedOut.delete();
        for (int slot = 0; slot < programLength; slot++) begin
            op = choices[$unsigned($random(seed)) % 7];
            ra = $random(seed);
            rb = $random(seed);
            c  = $random(seed);
            if (op == ld || op == st) begin
                rb = 4'd0;  // R0 base, absolute address
                c  = dataBase + ($unsigned($random(seed)) % 16) * 8;  // few slots, reuse likely
            end
            cExt        = {{13{c[18]}}, c};
            image[slot] = {op, ra, rb, c};
            case (op)
                ld: begin
                    modelRegs[ra] = modelMem[c[7:0]];
                end
                st: begin
                    modelMem[c[7:0]] = modelRegs[ra];
                end
                addi: begin
                    modelRegs[ra] = modelRegs[rb] + cExt;  // plain read of R0 is its value
                end
                andi: begin
                    modelRegs[ra] = modelRegs[rb] & cExt;
                end
                ori: begin
                    modelRegs[ra] = modelRegs[rb] | cExt;
                end
                outOp: begin
                    expectedOut.push_back(modelRegs[ra]);
                end
                default: begin
                end
            endcase
        end
        image[programLength] = {halt, 27'd0};
    endtask

    // preload fills the reset window, then a few idle reset cycles
    task automatic resetAndPreload();
        @(posedge clock);
        #1;
        reset = 1'b1;
        for (int a = 0; a < memWords; a++) begin
            if (a <= programLength || a >= dataBase) begin
                preloadWrite   = 1'b1;
                preloadAddress = a;
                preloadData    = image[a];
                @(posedge clock);
                #1;
            end
        end
        preloadWrite = 1'b0;
        repeat (resetCycles) @(posedge clock);
        #1;
        reset = 1'b0;
    endtask

    // next falling edge with outValid or halted high
    task automatic waitForEvent();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!outValid && !halted && cycles < eventTimeout) begin
            cycles++;
            @(negedge clock);
        end
        if (!outValid && !halted) begin
            timedOut = 1'b1;
            errorCount++;
            $display("timeout at t=%0t: neither outValid nor halted came within %0d cycles",
                     $time, eventTimeout);
        end
    endtask

    task automatic runProgram();
        int outSeen;
        bit finished;
        resetAndPreload();
        @(negedge clock);
        checkValue("outValid", outValid, 1'b0);  // first cycle out of reset
        checkValue("halted", halted, 1'b0);
        outSeen  = 0;
        finished = 1'b0;
        while (!finished) begin
            waitForEvent();
            if (timedOut) begin
                finished = 1'b1;
            end else if (outValid) begin
                if (outSeen < expectedOut.size()) begin
                    checkValue("outData", outData, expectedOut[outSeen]);
                end else begin
                    errorCount++;
                    $display("extra outValid pulse at t=%0t, only %0d out instructions",
                             $time, expectedOut.size());
                end
                outSeen++;
                @(negedge clock);
                checkValue("outValid", outValid, 1'b0);  // pulse is one cycle wide
            end else begin
                finished = 1'b1;  // halted reached
            end
        end
        if (!timedOut) begin
            checkValue("outValid count", outSeen, expectedOut.size());
            repeat (haltWatch) begin
                @(negedge clock);
                checkValue("halted", halted, 1'b1);  // stays up until reset
                checkValue("outValid", outValid, 1'b0);
            end
        end
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        preloadWrite   = 1'b0;
        preloadAddress = '0;
        preloadData    = '0;
        seed           = 32'hea0;
        errorCount     = 0;
        timedOut       = 1'b0;
        buildProgram();
        runProgram();
        if (!timedOut) begin
            runProgram();  // rerun, same program and data from PC zero
        end
        $display("run complete, %0d out values expected per run, %0d errors",
                 expectedOut.size(), errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: design/miniSrcTop.sv
`timescale 1ns/1ps

module miniSrcTop #(
    parameter int dataWidth  = 32,
    parameter int memWords   = 256,
    parameter int memLatency = 2     // 1..4, sets the wait steps too
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        preloadWrite,
    input  logic [$clog2(memWords)-1:0] preloadAddress,
    input  logic [dataWidth-1:0]        preloadData,
    output logic [dataWidth-1:0]        outData,
    output logic                        outValid,  // one cycle after out step
    output logic                        halted
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    logic [dataWidth-1:0]  bus;
    logic [dataWidth-1:0]  pc;
    logic [instrWidth-1:0] ir;
    logic [dataWidth-1:0]  y;
    logic [dataWidth-1:0]  z;
    logic [dataWidth-1:0]  cValue;     // sign-extended C
    logic [dataWidth-1:0]  regData;
    logic [dataWidth-1:0]  mdrValue;
    logic [dataWidth-1:0]  aluResult;
    opcodeT                opcode;
    aluOpT                 aluOp;
    logic pcOut, zLowOut, mdrOut, regOut, cOut;               // bus sources
    logic pcIn, irIn, yIn, zIn, marIn, mdrIn, outPortIn, regIn;
    logic gra, grb, grc, baOut, memRead, memWrite;

    assign opcode = opcodeT'(ir[opcodeMsb:opcodeLsb]);
    assign cValue = {{(dataWidth - constBits){ir[constMsb]}}, ir[constMsb:constLsb]};

    // and-or mux, idle bus reads zero
    assign bus = ({dataWidth{pcOut}}   & pc)
               | ({dataWidth{zLowOut}} & z)
               | ({dataWidth{mdrOut}}  & mdrValue)
               | ({dataWidth{regOut}}  & regData)
               | ({dataWidth{cOut}}    & cValue);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;  // start at word zero
        end else if (pcIn) begin
            pc <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (irIn) begin
            ir <= bus[instrWidth-1:0];
        end
        if (yIn) begin
            y <= bus;
        end
        if (zIn) begin
            z <= aluResult;
        end
        if (outPortIn) begin
            outData <= bus;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= outPortIn;
        end
    end

    controlSequencer #(
        .memLatency(memLatency)
    ) sequencer (
        .clock    (clock),
        .reset    (reset),
        .opcode   (opcode),
        .pcOut    (pcOut),
        .zLowOut  (zLowOut),
        .mdrOut   (mdrOut),
        .regOut   (regOut),
        .cOut     (cOut),
        .pcIn     (pcIn),
        .irIn     (irIn),
        .yIn      (yIn),
        .zIn      (zIn),
        .marIn    (marIn),
        .mdrIn    (mdrIn),
        .outPortIn(outPortIn),
        .regIn    (regIn),
        .gra      (gra),
        .grb      (grb),
        .grc      (grc),
        .baOut    (baOut),
        .memRead  (memRead),
        .memWrite (memWrite),
        .aluOp    (aluOp),
        .halted   (halted)
    );

    registerFile #(
        .dataWidth(dataWidth)
    ) registers (
        .clock      (clock),
        .reset      (reset),
        .instruction(ir),
        .gra        (gra),
        .grb        (grb),
        .grc        (grc),
        .baOut      (baOut),
        .regIn      (regIn),
        .busIn      (bus),
        .regData    (regData)
    );

    aluUnit #(
        .dataWidth(dataWidth)
    ) alu (
        .yValue  (y),
        .busValue(bus),
        .aluOp   (aluOp),
        .result  (aluResult)
    );

    memoryInterface #(
        .dataWidth (dataWidth),
        .memWords  (memWords),
        .memLatency(memLatency)
    ) memory (
        .clock         (clock),
        .reset         (reset),
        .busIn         (bus),
        .marIn         (marIn),
        .mdrIn         (mdrIn),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .preloadWrite  (preloadWrite),
        .preloadAddress(preloadAddress),
        .preloadData   (preloadData),
        .mdrValue      (mdrValue)
    );

    oneBusSource: assert property (@(posedge clock) disable iff (reset)
        $onehot0({pcOut, zLowOut, mdrOut, regOut, cOut}))
        else $error("miniSrcTop: more than one bus source enabled");

endmodule

// File: design/memoryInterface.sv
`timescale 1ns/1ps

module memoryInterface #(
    parameter int dataWidth  = 32,
    parameter int memWords   = 256,
    parameter int memLatency = 2
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [dataWidth-1:0]        busIn,
    input  logic                        marIn,
    input  logic                        mdrIn,
    input  logic                        memRead,         // one-cycle pulse
    input  logic                        memWrite,
    input  logic                        preloadWrite,    // taken only during reset
    input  logic [$clog2(memWords)-1:0] preloadAddress,
    input  logic [dataWidth-1:0]        preloadData,
    output logic [dataWidth-1:0]        mdrValue
);
    localparam int addrWidth = $clog2(memWords);

    logic [dataWidth-1:0]  memory [memWords];
    logic [addrWidth-1:0]  mar;       // word address bits only
    logic [dataWidth-1:0]  mdr;
    logic [memLatency-1:0] readPipe;  // read in flight, one bit per cycle

    always_ff @(posedge clock) begin
        if (marIn) begin
            mar <= busIn[addrWidth-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            readPipe <= '0;
        end else begin
            readPipe <= (readPipe << 1) | memLatency'(memRead);
        end
    end

    always_ff @(posedge clock) begin
        if (readPipe[memLatency-1]) begin
            mdr <= memory[mar];  // lands memLatency cycles after the pulse
        end else if (mdrIn) begin
            mdr <= busIn;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            if (preloadWrite) begin
                memory[preloadAddress] <= preloadData;
            end
        end else if (memWrite) begin
            memory[mar] <= mdr;
        end
    end

    assign mdrValue = mdr;

    noOverlappedRead: assert property (@(posedge clock) disable iff (reset)
        memRead |-> (readPipe == '0))
        else $error("memoryInterface: read issued while another is pending");

endmodule

// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit #(
    parameter int dataWidth = 32
) (
    input  logic [dataWidth-1:0]  yValue,    // left operand, Y register
    input  logic [dataWidth-1:0]  busValue,  // right operand, the bus
    input  srcDatapathPkg::aluOpT aluOp,
    output logic [dataWidth-1:0]  result     // latched into Z by the top
);
    import srcDatapathPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = yValue + busValue;  // also forms C(Rb) addresses
            end
            aluAnd: begin
                result = yValue & busValue;
            end
            aluOr: begin
                result = yValue | busValue;
            end
            aluIncrement: begin
                result = busValue + dataWidth'(1);  // PC+1 in fetch
            end
            default: begin
                result = busValue;  // aluPass
            end
        endcase
    end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
    parameter int dataWidth = 32
) (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [srcIsaPkg::instrWidth-1:0] instruction,  // IR contents
    input  logic                             gra,          // pick Ra field
    input  logic                             grb,          // pick Rb field
    input  logic                             grc,          // pick Rc field
    input  logic                             baOut,        // base-address read
    input  logic                             regIn,        // write bus to selected reg
    input  logic [dataWidth-1:0]             busIn,
    output logic [dataWidth-1:0]             regData
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    logic [dataWidth-1:0]     regs [regCount];
    logic [regIndexWidth-1:0] select;

    always_comb begin
        select = '0;
        if (gra) begin
            select = instruction[raMsb:raLsb];
        end else if (grb) begin
            select = instruction[rbMsb:rbLsb];
        end else if (grc) begin
            select = instruction[rcMsb:rcLsb];
        end
    end

    // R0 as a base gives absolute addressing
    assign regData = (baOut && select == '0) ? '0 : regs[select];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;  // a rerun starts from clean registers
            end
        end else if (regIn) begin
            regs[select] <= busIn;
        end
    end

    singleFieldSelect: assert property (@(posedge clock) disable iff (reset)
        $onehot0({gra, grb, grc}))
        else $error("registerFile: more than one register field selected");

endmodule

// File: design/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer #(
    parameter int memLatency = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  srcIsaPkg::opcodeT     opcode,     // straight from IR
    output logic                  pcOut,      // bus sources
    output logic                  zLowOut,
    output logic                  mdrOut,
    output logic                  regOut,
    output logic                  cOut,
    output logic                  pcIn,       // register loads
    output logic                  irIn,
    output logic                  yIn,
    output logic                  zIn,
    output logic                  marIn,
    output logic                  mdrIn,
    output logic                  outPortIn,
    output logic                  regIn,
    output logic                  gra,        // register field selects
    output logic                  grb,
    output logic                  grc,
    output logic                  baOut,
    output logic                  memRead,    // one-cycle pulse
    output logic                  memWrite,
    output srcDatapathPkg::aluOpT aluOp,
    output logic                  halted
);
    import srcIsaPkg::*;
    import srcDatapathPkg::*;

    localparam int waitBits = $clog2(memLatency + 1);

    typedef enum logic [3:0] {
        stepBoot, stepT0, stepT1, stepFetchWait, stepT2, stepT3,
        stepT4, stepT5, stepT6, stepExecWait, stepT7, stepHalt
    } stepT;

    stepT                step;
    stepT                nextStep;
    logic [waitBits-1:0] waitCount;  // steps spent in the current wait
    logic                lastWait;
    logic                memOp;      // ld or st

    assign lastWait = (waitCount == waitBits'(memLatency - 1));
    assign memOp    = (opcode == ld) || (opcode == st);

    always_ff @(posedge clock) begin
        if (reset) begin
            step      <= stepBoot;
            waitCount <= '0;
            halted    <= 1'b0;
        end else begin
            step   <= nextStep;
            halted <= (nextStep == stepHalt);  // lines up with the halt step
            if (nextStep == step && (step == stepFetchWait || step == stepExecWait)) begin
                waitCount <= waitCount + 1'b1;
            end else begin
                waitCount <= '0;
            end
        end
    end

    always_comb begin
        pcOut     = 1'b0;
        zLowOut   = 1'b0;
        mdrOut    = 1'b0;
        regOut    = 1'b0;
        cOut      = 1'b0;
        pcIn      = 1'b0;
        irIn      = 1'b0;
        yIn       = 1'b0;
        zIn       = 1'b0;
        marIn     = 1'b0;
        mdrIn     = 1'b0;
        outPortIn = 1'b0;
        regIn     = 1'b0;
        gra       = 1'b0;
        grb       = 1'b0;
        grc       = 1'b0;  // no three-register ops here
        baOut     = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        aluOp     = aluPass;
        nextStep  = step;
        case (step)
            stepBoot: begin
                nextStep = stepT0;
            end
            stepT0: begin  // MAR <- PC, Z <- PC+1
                pcOut    = 1'b1;
                marIn    = 1'b1;
                aluOp    = aluIncrement;
                zIn      = 1'b1;
                nextStep = stepT1;
            end
            stepT1: begin  // PC <- Z, start instruction read
                zLowOut  = 1'b1;
                pcIn     = 1'b1;
                memRead  = 1'b1;
                nextStep = stepFetchWait;
            end
            stepFetchWait: begin
                nextStep = lastWait ? stepT2 : stepFetchWait;
            end
            stepT2: begin  // IR <- MDR
                mdrOut   = 1'b1;
                irIn     = 1'b1;
                nextStep = stepT3;
            end
            stepT3: begin  // first execute step, IR now valid
                case (opcode)
                    ld, st: begin  // Y <- Rb, R0 as zero
                        grb      = 1'b1;
                        baOut    = 1'b1;
                        regOut   = 1'b1;
                        yIn      = 1'b1;
                        nextStep = stepT4;
                    end
                    addi, andi, ori: begin
                        grb      = 1'b1;
                        regOut   = 1'b1;
                        yIn      = 1'b1;
                        nextStep = stepT4;
                    end
                    outOp: begin
                        gra       = 1'b1;
                        regOut    = 1'b1;
                        outPortIn = 1'b1;
                        nextStep  = stepT0;
                    end
                    halt: begin
                        nextStep = stepHalt;
                    end
                    default: begin  // nop and unused codes
                        nextStep = stepT0;
                    end
                endcase
            end
            stepT4: begin  // Z <- Y op C
                cOut     = 1'b1;
                zIn      = 1'b1;
                aluOp    = (opcode == andi) ? aluAnd : (opcode == ori) ? aluOr : aluAdd;
                nextStep = stepT5;
            end
            stepT5: begin
                zLowOut = 1'b1;
                if (memOp) begin  // effective address to MAR
                    marIn    = 1'b1;
                    nextStep = stepT6;
                end else begin    // immediate result to Ra
                    gra      = 1'b1;
                    regIn    = 1'b1;
                    nextStep = stepT0;
                end
            end
            stepT6: begin
                if (opcode == ld) begin
                    memRead  = 1'b1;
                    nextStep = stepExecWait;
                end else begin  // st, MDR <- Ra
                    gra      = 1'b1;
                    regOut   = 1'b1;
                    mdrIn    = 1'b1;
                    nextStep = stepT7;
                end
            end
            stepExecWait: begin
                nextStep = lastWait ? stepT7 : stepExecWait;
            end
            stepT7: begin
                if (opcode == ld) begin  // Ra <- MDR
                    mdrOut = 1'b1;
                    gra    = 1'b1;
                    regIn  = 1'b1;
                end else begin
                    memWrite = 1'b1;
                end
                nextStep = stepT0;
            end
            default: begin  // stepHalt, left only by reset
                nextStep = stepHalt;
            end
        endcase
    end

    readWriteExclusive: assert property (@(posedge clock) disable iff (reset)
        !(memRead && memWrite))
        else $error("controlSequencer: memRead and memWrite high together");

endmodule

// File: design/srcDatapathPkg.sv
package srcDatapathPkg;

    typedef enum logic [2:0] {
        aluAdd       = 3'd0,  // Y + bus
        aluAnd       = 3'd1,
        aluOr        = 3'd2,
        aluIncrement = 3'd3,  // bus + 1, used for PC
        aluPass      = 3'd4   // bus straight through
    } aluOpT;

    localparam int regCount      = 16;  // R0..R15
    localparam int regIndexWidth = $clog2(regCount);

endpackage

// File: design/srcIsaPkg.sv
package srcIsaPkg;

    localparam int instrWidth = 32;  // one word per instruction

    typedef enum logic [4:0] {
        ld    = 5'b00000,  // ld Ra,C(Rb)
        st    = 5'b00010,  // st Ra,C(Rb)
        addi  = 5'b01100,
        andi  = 5'b01101,
        ori   = 5'b01110,
        outOp = 5'b10111,  // out Ra
        nop   = 5'b11010,
        halt  = 5'b11011
    } opcodeT;

    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;
    localparam int raMsb     = 26;  // destination / store source
    localparam int raLsb     = 23;
    localparam int rbMsb     = 22;  // base register
    localparam int rbLsb     = 19;
    localparam int rcMsb     = 18;  // overlaps C, three-register ops only
    localparam int rcLsb     = 15;
    localparam int constMsb  = 18;  // also the sign bit of C
    localparam int constLsb  = 0;
    localparam int constBits = constMsb - constLsb + 1;

endpackage
